// ==== dv/aluTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluTb;
    import aluPkg::*;

    localparam int DataWidth = 32;
    localparam int EdgeCount = 6;
    localparam int Rounds = 4;
    localparam int DivRounds = 20;
    localparam int SqrtRounds = 20;
    // Upper bound on the operations issued below
    localparam int NumOps = 64 * (EdgeCount * EdgeCount + Rounds)
        + 4 * (EdgeCount * EdgeCount + 2 * DivRounds + EdgeCount + 4)
        + EdgeCount + 2 * SqrtRounds + 10;
    localparam int CycleLimit = NumOps * 40 + 100;

    logic                 clock;
    logic                 reset;
    logic                 start;
    logic [5:0]           funcCode;
    logic [DataWidth-1:0] opA;
    logic [DataWidth-1:0] opB;
    logic                 done;
    logic [DataWidth-1:0] result;
    int                   seed;
    int                   cycles;
    int                   tests;
    int                   checks;
    int                   errors;
    int                   checkMark;
    int                   errorMark;
    logic [DataWidth-1:0] edgeValues [EdgeCount] = '{32'h0, 32'h1, 32'hffff_ffff,
                                                     32'h8000_0000, 32'h7fff_ffff, 32'd31};
    logic [5:0]           divCodes [4] = '{FuncDivSigned, FuncModSigned,
                                           FuncDivUnsigned, FuncModUnsigned};
    logic [5:0]           iterCodes [2] = '{FuncDivUnsigned, FuncSqrt};

    aluTop #(.DataWidth(DataWidth)) uut (
        .i_reset(clock),
        .i_clock(reset),
        .i_start(start),
        .i_funcCode(funcCode),
        .i_operandA(opA),
        .i_operandB(opB),
        .o_done(done),
        .o_result(result)
    );

    always #10 clock = ~clock;

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles > CycleLimit) begin
            $display("Timeout: the run did not end within %0d cycles", CycleLimit);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic logic [DataWidth-1:0] referenceResult(input logic [5:0] code,
            input logic [DataWidth-1:0] a, input logic [DataWidth-1:0] b);
        logic                         negA;
        logic                         negB;
        logic [DataWidth-1:0]         magA;
        logic [DataWidth-1:0]         magB;
        logic [DataWidth-1:0]         quo;
        logic [DataWidth-1:0]         rem;
        logic [DataWidth-1:0]         root;
        logic [2*DataWidth-1:0]       trial;
        logic [$clog2(DataWidth)-1:0] shamt;
        negA = (code inside {FuncDivSigned, FuncModSigned}) && a[DataWidth-1];
        negB = (code inside {FuncDivSigned, FuncModSigned}) && b[DataWidth-1];
        magA = negA ? -a : a;
        magB = negB ? -b : b;
        shamt = b[$clog2(DataWidth)-1:0];
        case (code)
            FuncAdd: return a + b;
            FuncSub: return a - b;
            FuncMul: return a * b;
            FuncSqrt: begin
                root = '0; // Greedy bit search for the largest root
                for (int bitPos = DataWidth / 2 - 1; bitPos >= 0; bitPos--) begin
                    trial = root | (DataWidth'(1) << bitPos);
                    if (trial * trial <= a) begin
                        root = trial[DataWidth-1:0];
                    end
                end
                return root;
            end
            FuncDivSigned, FuncModSigned, FuncDivUnsigned, FuncModUnsigned: begin
                if (b == '0) begin
                    quo = '1;
                    rem = magA;
                end else begin
                    quo = magA / magB;
                    rem = magA % magB;
                end
                if (negA != negB) begin
                    quo = -quo; // Truncation toward zero
                end
                if (negA) begin
                    rem = -rem;
                end
                return (code inside {FuncModSigned, FuncModUnsigned}) ? rem : quo;
            end
            FuncShiftLeftArith, FuncShiftLeftLogic: return a << shamt;
            FuncShiftRightArith: return $signed(a) >>> shamt;
            FuncShiftRightLogic: return a >> shamt;
            FuncEqual:    return DataWidth'(a == b);
            FuncNotEqual: return DataWidth'(a != b);
            FuncGreater:  return DataWidth'($signed(a) > $signed(b));
            FuncLess:     return DataWidth'($signed(a) < $signed(b));
            FuncGreaterU: return DataWidth'(a > b);
            FuncLessU:    return DataWidth'(a < b);
            FuncNot:      return ~a;
            FuncAnd:      return a & b;
            FuncOr:       return a | b;
            FuncXor:      return a ^ b;
            FuncXnor:     return ~(a ^ b);
            default:      return '0; // Float and unused codes
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [DataWidth-1:0] expected,
            input logic [DataWidth-1:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("error at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic issueStart(input logic [5:0] code, input logic [DataWidth-1:0] a,
            input logic [DataWidth-1:0] b);
        @(negedge clock);
        start = 1'b1;
        funcCode = code;
        opA = a;
        opB = b;
        @(negedge clock);
        start = 1'b0;
    endtask

    task automatic waitDone();
        while (!done) begin
            @(negedge clock);
        end
    endtask

    task automatic runOp(input logic [5:0] code, input logic [DataWidth-1:0] a,
            input logic [DataWidth-1:0] b);
        logic [DataWidth-1:0] expected;
        expected = referenceResult(code, a, b);
        issueStart(code, a, b);
        waitDone();
        checkValue("o_result", expected, result);
    endtask

    task automatic finishTest(input string name);
        tests++;
        $display("Test %0d %s: %0d checks, %0d errors", tests, name,
                 checks - checkMark, errors - errorMark);
        checkMark = checks;
        errorMark = errors;
    endtask

    task automatic applyReset();
        reset = 1'b1;
        repeat (4) @(negedge clock);
        reset = 1'b0;
    endtask

    initial begin
        logic [DataWidth-1:0] k;
        logic [DataWidth-1:0] expected;
        seed = 32'hafff_8ce3;
        clock = 1'b0;
        start = 1'b0;
        funcCode = '0;
        opA = '0;
        opB = '0;
        cycles = 0;
        tests = 0;
        checks = 0;
        errors = 0;
        checkMark = 0;
        errorMark = 0;
        applyReset();

        for (int code = 0; code < 64; code++) begin
            if (code inside {3, 4, 5, 36, 37}) begin
                continue; // Iterative codes get their own tests
            end
            for (int i = 0; i < EdgeCount; i++) begin
                for (int j = 0; j < EdgeCount; j++) begin
                    runOp(6'(code), edgeValues[i], edgeValues[j]);
                end
            end
            repeat (Rounds) runOp(6'(code), $random(seed), $random(seed));
        end
        finishTest("single-cycle codes");

        foreach (divCodes[c]) begin
            for (int i = 0; i < EdgeCount; i++) begin
                for (int j = 1; j < EdgeCount; j++) begin
                    runOp(divCodes[c], edgeValues[i], edgeValues[j]);
                end
            end
            repeat (DivRounds) runOp(divCodes[c], $random(seed), $random(seed));
            repeat (DivRounds) runOp(divCodes[c], $random(seed), $random(seed) % 16);
        end
        finishTest("divide and modulo");

        foreach (divCodes[c]) begin
            for (int i = 0; i < EdgeCount; i++) begin
                runOp(divCodes[c], edgeValues[i], '0);
            end
            repeat (4) runOp(divCodes[c], $random(seed), '0);
        end
        finishTest("division by zero");

        for (int i = 0; i < EdgeCount; i++) begin
            runOp(FuncSqrt, edgeValues[i], '0);
        end
        repeat (SqrtRounds) runOp(FuncSqrt, $random(seed), '0);
        repeat (SqrtRounds / 2) begin
            k = $random(seed) & 32'hffff;
            runOp(FuncSqrt, k * k, '0);
            runOp(FuncSqrt, k * k + 2 * k, '0); // Just below the next square
        end
        finishTest("square root");

        // Second start lands while busy and must be dropped
        foreach (iterCodes[c]) begin
            k = $random(seed);
            expected = referenceResult(iterCodes[c], k, 32'd7);
            issueStart(iterCodes[c], k, 32'd7);
            issueStart(FuncAdd, 32'd1, 32'd2);
            waitDone();
            checkValue("o_result", expected, result);
            @(negedge clock);
            checkValue("o_done", 1, DataWidth'(done));
            checkValue("o_result", expected, result);
        end
        finishTest("busy level and ignored start");

        issueStart(FuncSqrt, $random(seed), '0);
        repeat (5) @(negedge clock);
        applyReset();
        checkValue("o_done", 1, DataWidth'(done));
        checkValue("o_result", '0, result);
        runOp(FuncDivSigned, $random(seed), $random(seed) % 100);
        runOp(FuncSqrt, $random(seed), '0);
        finishTest("reset during an operation");

        $display("Tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests, checks, errors, uut.checks.failCount);
        if (errors == 0 && uut.checks.failCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/aluTop_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluTopAssertions #(
    parameter int DataWidth = 32
) (
    input wire logic                 i_reset,  // Clock, named as on aluTop
    input wire logic                 i_clock,  // Asynchronous reset
    input wire logic                 i_start,
    input wire logic [5:0]           i_funcCode,
    input wire logic                 i_done,
    input wire logic [DataWidth-1:0] i_result
);
    import aluPkg::*;

    localparam logic [1:0] KindNone = 2'd0;
    localparam logic [1:0] KindDiv  = 2'd1;
    localparam logic [1:0] KindSqrt = 2'd2;

    int         failCount = 0;
    int         busyCycles;
    logic [1:0] lastKind;
    logic       accept;
    logic       startDiv;
    logic       startSqrt;

    assign accept = i_start && i_done;
    assign startDiv = accept && (i_funcCode inside {FuncDivSigned, FuncModSigned,
                                                    FuncDivUnsigned, FuncModUnsigned});
    assign startSqrt = accept && (i_funcCode == FuncSqrt);

    // Counts the sampled busy cycles of the operation in flight
    always_ff @(posedge i_reset or posedge i_clock) begin
        if (i_clock) begin
            lastKind <= KindNone;
            busyCycles <= 0;
        end else if (accept) begin
            lastKind <= startDiv ? KindDiv : (startSqrt ? KindSqrt : KindNone);
            busyCycles <= 0;
        end else if (!i_done) begin
            busyCycles <= busyCycles + 1;
        end
    end

    resetState: assert property (@(posedge i_reset) i_clock |=> i_done && i_result == '0)
        else begin
            failCount = failCount + 1;
            $error("o_done not high or o_result not zero after reset");
        end

    busyOnIterative: assert property (@(posedge i_reset) disable iff (i_clock)
        startDiv || startSqrt |=> !i_done)
        else begin
            failCount = failCount + 1;
            $error("o_done did not fall after an iterative start");
        end

    divLatency: assert property (@(posedge i_reset) disable iff (i_clock)
        $rose(i_done) && lastKind == KindDiv |-> busyCycles == DataWidth + 1)
        else begin
            failCount = failCount + 1;
            $error("division busy for %0d cycles", busyCycles);
        end

    sqrtLatency: assert property (@(posedge i_reset) disable iff (i_clock)
        $rose(i_done) && lastKind == KindSqrt |-> busyCycles == DataWidth / 2 + 1)
        else begin
            failCount = failCount + 1;
            $error("square root busy for %0d cycles", busyCycles);
        end

    singleStaysDone: assert property (@(posedge i_reset) disable iff (i_clock)
        accept && !startDiv && !startSqrt |=> i_done)
        else begin
            failCount = failCount + 1;
            $error("o_done fell on a single-cycle code");
        end

    resultHeld: assert property (@(posedge i_reset) disable iff (i_clock)
        i_done && !i_start |=> $stable(i_result))
        else begin
            failCount = failCount + 1;
            $error("o_result changed while idle");
        end

endmodule

bind aluTop aluTopAssertions #(.DataWidth(DataWidth)) checks (
    .i_reset(i_reset),
    .i_clock(i_clock),
    .i_start(i_start),
    .i_funcCode(i_funcCode),
    .i_done(o_done),
    .i_result(o_result)
);

`default_nettype wire

// ==== filelist.f ====
logic/aluPkg.sv
logic/cycleTimer.sv
logic/simpleAlu.sv
logic/iterDivider.sv
logic/iterSqrt.sv
logic/aluController.sv
logic/aluTop.sv
dv/aluTop_assertions.sv
dv/aluTb.sv

// ==== logic/aluController.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluController #(
    parameter int DataWidth = 32,
    localparam int CountWidth = $clog2(DataWidth + 1)
) (
    input  wire logic                  i_reset,
    input  wire logic                  i_clock,
    input  wire logic                  i_start,
    input  wire logic [5:0]            i_funcCode,
    input  wire logic [DataWidth-1:0]  i_operandA,
    input  wire logic [DataWidth-1:0]  i_operandB,
    input  wire logic                  i_timerExpire,
    input  wire logic [DataWidth-1:0]  i_simpleResult,
    input  wire logic [DataWidth-1:0]  i_divResult,
    input  wire logic [DataWidth-1:0]  i_sqrtResult,
    output logic [DataWidth-1:0]       o_opA,
    output logic [DataWidth-1:0]       o_opB,
    output aluPkg::funcWord            o_func,
    output logic                       o_divStart,
    output logic                       o_sqrtStart,
    output logic                       o_timerLoad,
    output logic [CountWidth-1:0]      o_timerCount,
    output logic                       o_done,
    output logic [DataWidth-1:0]       o_result
);
    import aluPkg::*;

    localparam logic [1:0] StIdle     = 2'd0;
    localparam logic [1:0] StWaitDiv  = 2'd1;
    localparam logic [1:0] StWaitSqrt = 2'd2;

    logic [1:0]           state;
    logic                 expireDly; // Unit result settles one edge after expire
    logic                 accept;
    logic                 isDiv;
    logic                 isSqrt;
    funcWord              inWord;
    funcWord              funcReg;
    logic [DataWidth-1:0] opAReg;
    logic [DataWidth-1:0] opBReg;

    assign inWord = i_funcCode;
    assign accept = i_start && (state == StIdle);
    assign o_done = (state == StIdle);

    always_comb begin
        isDiv = 1'b0;
        isSqrt = 1'b0;
        case (inWord.fields.group)
            GroupInt: begin
                isDiv = inWord.code inside {FuncDivSigned, FuncModSigned};
                isSqrt = (inWord.code == FuncSqrt);
            end
            GroupLogic: ; // Always single cycle
            GroupFloat: isDiv = inWord.code inside {FuncDivUnsigned, FuncModUnsigned};
            default: ;
        endcase
    end

    // While idle the units see the incoming word so they can load on the accepting edge
    assign o_opA = (state == StIdle) ? i_operandA : opAReg;
    assign o_opB = (state == StIdle) ? i_operandB : opBReg;
    assign o_func = (state == StIdle) ? inWord : funcReg;

    assign o_divStart = accept && isDiv;
    assign o_sqrtStart = accept && isSqrt;
    assign o_timerLoad = accept && (isDiv || isSqrt);
    assign o_timerCount = isDiv ? CountWidth'(DataWidth) : CountWidth'(DataWidth / 2);

    always_ff @(posedge i_reset or posedge i_clock) begin
        if (i_clock) begin
            state <= StIdle;
            expireDly <= 1'b0;
            o_result <= '0;
        end else begin
            expireDly <= i_timerExpire;
            case (state)
                StIdle: begin
                    if (accept) begin
                        if (isDiv) begin
                            state <= StWaitDiv;
                        end else if (isSqrt) begin
                            state <= StWaitSqrt;
                        end else begin
                            o_result <= i_simpleResult; // Single cycle
                        end
                    end
                end
                StWaitDiv: begin
                    if (expireDly) begin
                        o_result <= i_divResult;
                        state <= StIdle;
                    end
                end
                StWaitSqrt: begin
                    if (expireDly) begin
                        o_result <= i_sqrtResult;
                        state <= StIdle;
                    end
                end
                default: state <= StIdle;
            endcase
        end
    end

    always_ff @(posedge i_reset) begin
        if (accept) begin
            opAReg <= i_operandA;
            opBReg <= i_operandB;
            funcReg <= inWord;
        end
    end

endmodule

`default_nettype wire

// ==== logic/aluPkg.sv ====
`default_nettype none

package aluPkg;

    // Function codes, one per operation
    typedef enum logic [5:0] {
        FuncAdd             = 6'd0,
        FuncSub             = 6'd1,
        FuncMul             = 6'd2,
        FuncSqrt            = 6'd3,
        FuncDivSigned       = 6'd4,
        FuncModSigned       = 6'd5,
        FuncShiftLeftArith  = 6'd6,
        FuncShiftRightArith = 6'd7,
        FuncEqual           = 6'd8,
        FuncNotEqual        = 6'd9,
        FuncGreater         = 6'd10,
        FuncLess            = 6'd11,
        FuncGreaterU        = 6'd12,
        FuncLessU           = 6'd13,
        FuncNot             = 6'd16,
        FuncAnd             = 6'd17,
        FuncOr              = 6'd18,
        FuncXor             = 6'd19,
        FuncXnor            = 6'd20,
        FuncShiftLeftLogic  = 6'd22,
        FuncShiftRightLogic = 6'd23,
        FuncDivUnsigned     = 6'd36, // Borrowed from the float group
        FuncModUnsigned     = 6'd37
    } funcCode;

    localparam logic [1:0] GroupInt   = 2'd0;
    localparam logic [1:0] GroupLogic = 2'd1;
    localparam logic [1:0] GroupFloat = 2'd2;

    // Same six bits seen as a code or as group plus operation index
    typedef union packed {
        funcCode code;
        struct packed {
            logic [1:0] group;
            logic [3:0] index; // Bit 0 selects remainder in the divider
        } fields;
    } funcWord;

    // Division runs DataWidth steps and square root DataWidth/2 steps
    // One more edge moves the unit result into the output register
    // Everything else completes on the accepting edge

endpackage

`default_nettype wire

// ==== logic/aluTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluTop #(
    parameter int DataWidth = 32
) (
    input  wire logic                 i_reset,
    input  wire logic                 i_clock,
    input  wire logic                 i_start,
    input  wire logic [5:0]           i_funcCode,
    input  wire logic [DataWidth-1:0] i_operandA,
    input  wire logic [DataWidth-1:0] i_operandB,
    output logic                      o_done,
    output logic [DataWidth-1:0]      o_result
);
    import aluPkg::*;

    localparam int CountWidth = $clog2(DataWidth + 1);

    logic [DataWidth-1:0]  opA;
    logic [DataWidth-1:0]  opB;
    funcWord               func;
    logic                  divStart;
    logic                  sqrtStart;
    logic                  timerLoad;
    logic [CountWidth-1:0] timerCount;
    logic                  stepEnable;
    logic                  timerExpire;
    logic [DataWidth-1:0]  simpleResult;
    logic [DataWidth-1:0]  divResult;
    logic [DataWidth-1:0]  sqrtResult;

    aluController #(.DataWidth(DataWidth)) controller (
        .i_reset(i_reset),
        .i_clock(i_clock),
        .i_start(i_start),
        .i_funcCode(i_funcCode),
        .i_operandA(i_operandA),
        .i_operandB(i_operandB),
        .i_timerExpire(timerExpire),
        .i_simpleResult(simpleResult),
        .i_divResult(divResult),
        .i_sqrtResult(sqrtResult),
        .o_opA(opA),
        .o_opB(opB),
        .o_func(func),
        .o_divStart(divStart),
        .o_sqrtStart(sqrtStart),
        .o_timerLoad(timerLoad),
        .o_timerCount(timerCount),
        .o_done(o_done),
        .o_result(o_result)
    );

    cycleTimer #(.DataWidth(DataWidth)) timer (
        .i_reset(i_reset),
        .i_clock(i_clock),
        .i_load(timerLoad),
        .i_count(timerCount),
        .o_stepEnable(stepEnable),
        .o_expire(timerExpire)
    );

    simpleAlu #(.DataWidth(DataWidth)) simple (
        .i_opA(opA),
        .i_opB(opB),
        .i_func(func),
        .o_result(simpleResult)
    );

    iterDivider #(.DataWidth(DataWidth)) divider (
        .i_reset(i_reset),
        .i_clock(i_clock),
        .i_start(divStart),
        .i_step(stepEnable),
        .i_opA(opA),
        .i_opB(opB),
        .i_func(func),
        .o_result(divResult)
    );

    iterSqrt #(.DataWidth(DataWidth)) sqrtUnit (
        .i_reset(i_reset),
        .i_clock(i_clock),
        .i_start(sqrtStart),
        .i_step(stepEnable),
        .i_opA(opA),
        .o_result(sqrtResult)
    );

endmodule

`default_nettype wire

// ==== logic/cycleTimer.sv ====
`timescale 1ns/1ps
`default_nettype none

module cycleTimer #(
    parameter int DataWidth = 32,
    localparam int CountWidth = $clog2(DataWidth + 1)
) (
    input  wire logic                  i_reset,
    input  wire logic                  i_clock,
    input  wire logic                  i_load,
    input  wire logic [CountWidth-1:0] i_count,
    output logic                       o_stepEnable,
    output logic                       o_expire
);

    logic [CountWidth-1:0] count;

    always_ff @(posedge i_reset or posedge i_clock) begin
        if (i_clock) begin
            count <= '0;
        end else if (i_load) begin
            count <= i_count;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign o_stepEnable = (count != '0);
    assign o_expire = (count == CountWidth'(1)); // Last step happens on this cycle's edge

endmodule

`default_nettype wire

// ==== logic/iterDivider.sv ====
`timescale 1ns/1ps
`default_nettype none

module iterDivider #(
    parameter int DataWidth = 32
) (
    input  wire logic                 i_reset,
    input  wire logic                 i_clock,
    input  wire logic                 i_start,
    input  wire logic                 i_step,
    input  wire logic [DataWidth-1:0] i_opA,
    input  wire logic [DataWidth-1:0] i_opB,
    input  wire aluPkg::funcWord      i_func,
    output logic [DataWidth-1:0]      o_result
);
    import aluPkg::*;

    logic                 signedOp;
    logic                 negA;
    logic                 negB;
    logic                 negQuo;
    logic                 negRem;
    logic                 remSel;
    logic [DataWidth-1:0] remReg;    // Partial remainder always below the divisor
    logic [DataWidth-1:0] quoReg;    // Dividend bits shift out as quotient bits shift in
    logic [DataWidth-1:0] divisorReg;
    logic [DataWidth:0]   shifted;
    logic [DataWidth:0]   diff;
    logic [DataWidth-1:0] quoFinal;
    logic [DataWidth-1:0] remFinal;

    assign signedOp = (i_func.fields.group == GroupInt);
    assign negA = signedOp && i_opA[DataWidth-1];
    assign negB = signedOp && i_opB[DataWidth-1];

    always_ff @(posedge i_reset or posedge i_clock) begin
        if (i_clock) begin
            negQuo <= 1'b0;
            negRem <= 1'b0;
            remSel <= 1'b0;
        end else if (i_start) begin
            negQuo <= negA ^ negB;
            negRem <= negA;      // Remainder follows the dividend
            remSel <= i_func.fields.index[0];
        end
    end

    assign shifted = {remReg, quoReg[DataWidth-1]};
    assign diff = shifted - {1'b0, divisorReg};

    always_ff @(posedge i_reset) begin
        if (i_start) begin
            remReg <= '0;
            quoReg <= negA ? -i_opA : i_opA;
            divisorReg <= negB ? -i_opB : i_opB;
        end else if (i_step) begin
            if (!diff[DataWidth]) begin
                remReg <= diff[DataWidth-1:0];
                quoReg <= {quoReg[DataWidth-2:0], 1'b1};
            end else begin
                remReg <= shifted[DataWidth-1:0]; // Restore
                quoReg <= {quoReg[DataWidth-2:0], 1'b0};
            end
        end
    end

    // A zero divisor never fails the compare, so the quotient fills with ones
    assign quoFinal = negQuo ? -quoReg : quoReg;
    assign remFinal = negRem ? -remReg : remReg;
    assign o_result = remSel ? remFinal : quoFinal;

endmodule

`default_nettype wire

// ==== logic/iterSqrt.sv ====
`timescale 1ns/1ps
`default_nettype none

module iterSqrt #(
    parameter int DataWidth = 32
) (
    input  wire logic                 i_reset,
    input  wire logic                 i_clock,
    input  wire logic                 i_start,
    input  wire logic                 i_step,
    input  wire logic [DataWidth-1:0] i_opA,
    output logic [DataWidth-1:0]      o_result
);

    localparam int RootWidth = DataWidth / 2;
    localparam int RemWidth = RootWidth + 2;

    logic [DataWidth-1:0] radReg;  // Bit pairs leave from the top
    logic [RemWidth-1:0]  remReg;
    logic [RootWidth-1:0] rootReg;
    logic [RemWidth-1:0]  remShift;
    logic [RemWidth-1:0]  trial;

    assign remShift = {remReg[RemWidth-3:0], radReg[DataWidth-1 -: 2]};
    assign trial = {rootReg, 2'b01}; // 4*root + 1

    always_ff @(posedge i_reset or posedge i_clock) begin
        if (i_clock) begin
            radReg <= '0;
            remReg <= '0;
            rootReg <= '0;
        end else if (i_start) begin
            radReg <= i_opA;
            remReg <= '0;
            rootReg <= '0;
        end else if (i_step) begin
            radReg <= radReg << 2;
            if (remShift >= trial) begin
                remReg <= remShift - trial;
                rootReg <= {rootReg[RootWidth-2:0], 1'b1};
            end else begin
                remReg <= remShift;
                rootReg <= {rootReg[RootWidth-2:0], 1'b0};
            end
        end
    end

    assign o_result = DataWidth'(rootReg);

endmodule

`default_nettype wire

// ==== logic/simpleAlu.sv ====
`timescale 1ns/1ps
`default_nettype none

module simpleAlu #(
    parameter int DataWidth = 32
) (
    input  wire logic [DataWidth-1:0] i_opA,
    input  wire logic [DataWidth-1:0] i_opB,
    input  wire aluPkg::funcWord      i_func,
    output logic [DataWidth-1:0]      o_result
);
    import aluPkg::*;

    localparam int ShiftWidth = $clog2(DataWidth);

    logic [ShiftWidth-1:0] shamt;
    logic signed [DataWidth-1:0] sA;
    logic signed [DataWidth-1:0] sB;

    assign shamt = i_opB[ShiftWidth-1:0];
    assign sA = i_opA;
    assign sB = i_opB;

    always_comb begin
        case (i_func.code)
            FuncAdd:             o_result = i_opA + i_opB;
            FuncSub:             o_result = i_opA - i_opB;
            FuncMul:             o_result = i_opA * i_opB; // Low word, same for signed
            FuncShiftLeftArith:  o_result = i_opA << shamt;
            FuncShiftRightArith: o_result = sA >>> shamt;
            FuncEqual:           o_result = DataWidth'(i_opA == i_opB);
            FuncNotEqual:        o_result = DataWidth'(i_opA != i_opB);
            FuncGreater:         o_result = DataWidth'(sA > sB);
            FuncLess:            o_result = DataWidth'(sA < sB);
            FuncGreaterU:        o_result = DataWidth'(i_opA > i_opB);
            FuncLessU:           o_result = DataWidth'(i_opA < i_opB);
            FuncNot:             o_result = ~i_opA;
            FuncAnd:             o_result = i_opA & i_opB;
            FuncOr:              o_result = i_opA | i_opB;
            FuncXor:             o_result = i_opA ^ i_opB;
            FuncXnor:            o_result = i_opA ~^ i_opB;
            FuncShiftLeftLogic:  o_result = i_opA << shamt;
            FuncShiftRightLogic: o_result = i_opA >> shamt;
            // Iterative ops come from their own units, float codes give zero
            default:             o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Compile and run the ALU testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module aluTb -f filelist.f -o aluSim

# A failed bound assertion must not stop the run before the summary
./obj_dir/aluSim +verilator+error+limit+1000 | tee sim.log

if grep -q "^Finished with no errors$" sim.log; then
    exit 0
else
    exit 1
fi
